//--- verilog/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

typedef logic [31:0] arch_width_t;
typedef logic [4:0] rf_addr_t;

localparam rf_addr_t RF_X0_ZERO = 5'd0;

typedef enum logic [6:0] {
    OPC7_R_TYPE = 7'b011_0011,
    OPC7_I_TYPE = 7'b001_0011,
    OPC7_LOAD   = 7'b000_0011,
    OPC7_STORE  = 7'b010_0011,
    OPC7_BRANCH = 7'b110_0011,
    OPC7_JAL    = 7'b110_1111,
    OPC7_JALR   = 7'b110_0111,
    OPC7_LUI    = 7'b011_0111,
    OPC7_AUIPC  = 7'b001_0111,
    OPC7_CUSTOM = 7'b000_1011, // custom-0, simd dot and widen
    OPC7_SYSTEM = 7'b111_0011
} opc7_t;

// one struct per base format, msb first
typedef struct packed {
    logic [6:0] fn7;
    rf_addr_t rs2;
    rf_addr_t rs1;
    logic [2:0] fn3;
    rf_addr_t rd;
    opc7_t opc7;
} inst_r_t;

typedef struct packed {
    logic [11:0] imm_11_0;
    rf_addr_t rs1;
    logic [2:0] fn3;
    rf_addr_t rd;
    opc7_t opc7;
} inst_i_t;

typedef struct packed {
    logic [6:0] imm_11_5;
    rf_addr_t rs2;
    rf_addr_t rs1;
    logic [2:0] fn3;
    logic [4:0] imm_4_0;
    opc7_t opc7;
} inst_s_t;

typedef struct packed {
    logic imm_12;
    logic [5:0] imm_10_5;
    rf_addr_t rs2;
    rf_addr_t rs1;
    logic [2:0] fn3;
    logic [3:0] imm_4_1;
    logic imm_11;
    opc7_t opc7;
} inst_b_t;

typedef struct packed {
    logic [19:0] imm_31_12;
    rf_addr_t rd;
    opc7_t opc7;
} inst_u_t;

typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    rf_addr_t rd;
    opc7_t opc7;
} inst_j_t;

typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
    arch_width_t raw;
} inst_t;

typedef enum logic {
    A_SEL_RS1 = 1'b0,
    A_SEL_PC  = 1'b1
} a_sel_t;

typedef enum logic {
    B_SEL_RS2 = 1'b0,
    B_SEL_IMM = 1'b1
} b_sel_t;

// {fn7[5], fn3}
typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'b0000,
    ALU_OP_SLL  = 4'b0001,
    ALU_OP_SLT  = 4'b0010,
    ALU_OP_SLTU = 4'b0011,
    ALU_OP_XOR  = 4'b0100,
    ALU_OP_SRL  = 4'b0101,
    ALU_OP_OR   = 4'b0110,
    ALU_OP_AND  = 4'b0111,
    ALU_OP_SUB  = 4'b1000,
    ALU_OP_SRA  = 4'b1101
} alu_op_t;

typedef enum logic [1:0] {
    WB_SEL_EWB  = 2'd0,
    WB_SEL_DMEM = 2'd1,
    WB_SEL_SIMD = 2'd2
} wb_sel_t;

typedef enum logic [2:0] {
    EWB_SEL_ALU      = 3'd0,
    EWB_SEL_PC_INC4  = 3'd1,
    EWB_SEL_IMM_U    = 3'd2,
    EWB_SEL_CSR      = 3'd3,
    EWB_SEL_DATA_FMT = 3'd4
} ewb_sel_t;

typedef enum logic [1:0] {
    PC_SEL_INC4    = 2'd0,
    PC_SEL_JAL_BP  = 2'd1,
    PC_SEL_RESOLVE = 2'd2
} pc_sel_t;

endpackage

`default_nettype wire

//--- verilog/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

typedef struct packed {
    riscv_isa_pkg::arch_width_t pc;
    riscv_isa_pkg::inst_t inst;
} fetch_pkt_t;

// at most one flag set per instruction
typedef struct packed {
    logic load;
    logic store;
    logic branch;
    logic jal;
    logic jalr;
    logic mult;
    logic data_fmt;
    logic csr;
    logic illegal;
} itype_t;

typedef struct packed {
    logic rd;
    logic rs1;
    logic rs2;
} has_reg_t;

typedef struct packed {
    riscv_isa_pkg::arch_width_t pc;
    itype_t itype;
    riscv_isa_pkg::rf_addr_t rs1;
    riscv_isa_pkg::rf_addr_t rs2;
    riscv_isa_pkg::rf_addr_t rd;
    logic rd_we;
    riscv_isa_pkg::a_sel_t a_sel;
    riscv_isa_pkg::b_sel_t b_sel;
    riscv_isa_pkg::alu_op_t alu_op;
    riscv_isa_pkg::wb_sel_t wb_sel;
    riscv_isa_pkg::ewb_sel_t ewb_sel;
    riscv_isa_pkg::arch_width_t imm;
    has_reg_t has_reg;
    logic branch_u;
    logic dmem_en;
} decoded_t;

typedef struct packed {
    riscv_isa_pkg::pc_sel_t pc_sel;
    logic pc_we;
} fe_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter riscv_isa_pkg::arch_width_t RESET_PC = '0
) (
    input  logic clk,
    input  logic reset,
    output logic imem_req,
    output riscv_isa_pkg::arch_width_t imem_addr,
    input  riscv_isa_pkg::arch_width_t imem_rdata,
    input  logic credit_return,
    output logic fq_push,
    output frontend_pkg::fetch_pkt_t fq_pkt
);

localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

logic [CNT_W-1:0] credits;
logic issue;
riscv_isa_pkg::arch_width_t pc;
riscv_isa_pkg::arch_width_t req_pc;

// a credit coming back this cycle can be spent right away
assign issue = (credits != '0) || credit_return;

always_ff @(posedge clk) begin
    if (reset) begin
        pc <= RESET_PC;
        credits <= CNT_W'(QUEUE_DEPTH);
        imem_req <= 1'b0;
        fq_push <= 1'b0;
    end else begin
        if (issue) pc <= pc + 32'd4;
        credits <= credits - CNT_W'(issue) + CNT_W'(credit_return);
        imem_req <= issue;
        fq_push <= imem_req;
    end
end

always_ff @(posedge clk) begin
    if (issue) imem_addr <= pc;
    if (imem_req) req_pc <= imem_addr;
end

// memory data arrives the cycle after the request
assign fq_pkt.pc = req_pc;
assign fq_pkt.inst.raw = imem_rdata;

// queue must never return more credits than it has entries
credit_bound_a: assert property (
    @(posedge clk) disable iff (reset) credits <= CNT_W'(QUEUE_DEPTH)
) else $error("fetch credit count above queue depth");

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic fq_push,
    input  frontend_pkg::fetch_pkt_t fq_pkt,
    input  logic fq_pop,
    output logic fq_valid,
    output frontend_pkg::fetch_pkt_t fq_head,
    output logic credit_return
);

localparam int PTR_W = $clog2(QUEUE_DEPTH);

frontend_pkg::fetch_pkt_t entries [QUEUE_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0] count;
logic full;

assign full = (count == (PTR_W + 1)'(QUEUE_DEPTH));
assign fq_valid = (count != '0);
// show-ahead head entry
assign fq_head = entries[rd_ptr];

always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
        credit_return <= 1'b0;
    end else begin
        if (fq_push) wr_ptr <= wr_ptr + 1'b1;
        if (fq_pop) rd_ptr <= rd_ptr + 1'b1;
        count <= count + (PTR_W + 1)'(fq_push) - (PTR_W + 1)'(fq_pop);
        // one credit per freed entry
        credit_return <= fq_pop;
    end
end

always_ff @(posedge clk) begin
    if (fq_push) entries[wr_ptr] <= fq_pkt;
end

// the fetch credit counter is what keeps pushes off a full queue
no_push_full_a: assert property (
    @(posedge clk) disable iff (reset) fq_push |-> !full
) else $error("push into full fetch queue");

no_pop_empty_a: assert property (
    @(posedge clk) disable iff (reset) fq_pop |-> fq_valid
) else $error("pop from empty fetch queue");

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  riscv_isa_pkg::inst_t inst,
    input  riscv_isa_pkg::arch_width_t pc,
    output frontend_pkg::decoded_t decoded,
    output frontend_pkg::fe_ctrl_t fe_ctrl
);

riscv_isa_pkg::opc7_t opc7;
logic [2:0] fn3;
logic fn7_b5;
logic fn7_b0;
logic rd_nz;
riscv_isa_pkg::arch_width_t imm_i;
riscv_isa_pkg::arch_width_t imm_s;
riscv_isa_pkg::arch_width_t imm_b;
riscv_isa_pkg::arch_width_t imm_u;
riscv_isa_pkg::arch_width_t imm_j;
frontend_pkg::decoded_t d;
frontend_pkg::fe_ctrl_t fc;

assign opc7 = inst.r.opc7;
assign fn3 = inst.r.fn3;
assign fn7_b5 = inst.r.fn7[5];
assign fn7_b0 = inst.r.fn7[0];
assign rd_nz = (inst.r.rd != riscv_isa_pkg::RF_X0_ZERO);

// immediates, each from its own format view
assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
assign imm_u = {inst.u.imm_31_12, 12'd0};
assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                inst.j.imm_11, inst.j.imm_10_1, 1'b0};

assign decoded = d;
assign fe_ctrl = fc;

always_comb begin
    d = '0;
    fc = '0;
    d.pc = pc;
    d.rs1 = inst.r.rs1;
    d.rs2 = inst.r.rs2;
    d.rd = inst.r.rd;

    // branch and jalr leave pc_we low, the target is resolved later
    case (opc7)
        riscv_isa_pkg::OPC7_R_TYPE: begin
            fc.pc_we = 1'b1;
            d.itype.mult = fn7_b0;
            d.alu_op = riscv_isa_pkg::alu_op_t'({fn7_b5, fn3});
            d.wb_sel = fn7_b0 ? riscv_isa_pkg::WB_SEL_SIMD : riscv_isa_pkg::WB_SEL_EWB;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b1, rs2: 1'b1};
        end
        riscv_isa_pkg::OPC7_I_TYPE: begin
            fc.pc_we = 1'b1;
            d.b_sel = riscv_isa_pkg::B_SEL_IMM;
            // only shifts carry fn7[5]
            d.alu_op = (fn3[1:0] == 2'b01) ? riscv_isa_pkg::alu_op_t'({fn7_b5, fn3}) :
                                             riscv_isa_pkg::alu_op_t'({1'b0, fn3});
            d.imm = imm_i;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b1, rs2: 1'b0};
        end
        riscv_isa_pkg::OPC7_LOAD: begin
            fc.pc_we = 1'b1;
            d.itype.load = 1'b1;
            d.imm = imm_i;
            d.dmem_en = 1'b1;
            d.wb_sel = riscv_isa_pkg::WB_SEL_DMEM;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b1, rs2: 1'b0};
        end
        riscv_isa_pkg::OPC7_STORE: begin
            fc.pc_we = 1'b1;
            d.itype.store = 1'b1;
            d.imm = imm_s;
            d.dmem_en = 1'b1;
            d.has_reg = '{rd: 1'b0, rs1: 1'b1, rs2: 1'b1};
        end
        riscv_isa_pkg::OPC7_BRANCH: begin
            d.itype.branch = 1'b1;
            d.imm = imm_b;
            d.branch_u = fn3[1];
            d.has_reg = '{rd: 1'b0, rs1: 1'b1, rs2: 1'b1};
        end
        riscv_isa_pkg::OPC7_JAL: begin
            fc.pc_sel = riscv_isa_pkg::PC_SEL_JAL_BP;
            fc.pc_we = 1'b1;
            d.itype.jal = 1'b1;
            d.imm = imm_j;
            d.ewb_sel = riscv_isa_pkg::EWB_SEL_PC_INC4;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b0, rs2: 1'b0};
        end
        riscv_isa_pkg::OPC7_JALR: begin
            d.itype.jalr = 1'b1;
            d.b_sel = riscv_isa_pkg::B_SEL_IMM;
            d.imm = imm_i;
            d.ewb_sel = riscv_isa_pkg::EWB_SEL_PC_INC4;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b1, rs2: 1'b0};
        end
        riscv_isa_pkg::OPC7_LUI: begin
            fc.pc_we = 1'b1;
            d.b_sel = riscv_isa_pkg::B_SEL_IMM;
            d.imm = imm_u;
            d.ewb_sel = riscv_isa_pkg::EWB_SEL_IMM_U;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b0, rs2: 1'b0};
        end
        riscv_isa_pkg::OPC7_AUIPC: begin
            fc.pc_we = 1'b1;
            d.a_sel = riscv_isa_pkg::A_SEL_PC;
            d.b_sel = riscv_isa_pkg::B_SEL_IMM;
            d.imm = imm_u;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b0, rs2: 1'b0};
        end
        riscv_isa_pkg::OPC7_CUSTOM: begin
            fc.pc_we = 1'b1;
            d.rd_we = rd_nz;
            d.has_reg = '{rd: 1'b1, rs1: 1'b1, rs2: 1'b1};
            // fn3[0] picks widen over dot product
            if (fn3[0]) begin
                d.itype.data_fmt = 1'b1;
                d.ewb_sel = riscv_isa_pkg::EWB_SEL_DATA_FMT;
            end else begin
                d.itype.mult = 1'b1;
                d.wb_sel = riscv_isa_pkg::WB_SEL_SIMD;
            end
        end
        riscv_isa_pkg::OPC7_SYSTEM: begin
            fc.pc_we = 1'b1;
            d.itype.csr = 1'b1;
            d.ewb_sel = riscv_isa_pkg::EWB_SEL_CSR;
            d.rd_we = rd_nz;
            // immediate forms take uimm in the rs1 field
            d.has_reg = '{rd: 1'b1, rs1: !fn3[2], rs2: 1'b0};
        end
        default: begin
            d.itype.illegal = 1'b1;
        end
    endcase
end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic clk,
    input  logic reset,
    input  logic fq_valid,
    input  frontend_pkg::fetch_pkt_t fq_head,
    output logic fq_pop,
    output logic dec_valid,
    input  logic dec_ready,
    output frontend_pkg::decoded_t dec_out,
    output frontend_pkg::fe_ctrl_t fe_ctrl
);

frontend_pkg::decoded_t dec_next;
frontend_pkg::fe_ctrl_t fe_ctrl_next;

inst_decoder i_inst_decoder (
    .inst(fq_head.inst),
    .pc(fq_head.pc),
    .decoded(dec_next),
    .fe_ctrl(fe_ctrl_next)
);

// take a new word when the output register is empty or draining
assign fq_pop = fq_valid && (!dec_valid || dec_ready);

always_ff @(posedge clk) begin
    if (reset) begin
        dec_valid <= 1'b0;
    end else if (fq_pop) begin
        dec_valid <= 1'b1;
    end else if (dec_ready) begin
        dec_valid <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (fq_pop) begin
        dec_out <= dec_next;
        fe_ctrl <= fe_ctrl_next;
    end
end

stall_hold_a: assert property (
    @(posedge clk) disable iff (reset)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_out) && $stable(fe_ctrl)
) else $error("decode output changed while stalled");

endmodule

`default_nettype wire

//--- verilog/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter riscv_isa_pkg::arch_width_t RESET_PC = '0
) (
    input  logic clk,
    input  logic reset,
    output logic imem_req,
    output riscv_isa_pkg::arch_width_t imem_addr,
    input  riscv_isa_pkg::arch_width_t imem_rdata,
    output logic dec_valid,
    input  logic dec_ready,
    output frontend_pkg::decoded_t dec_out,
    output frontend_pkg::fe_ctrl_t fe_ctrl
);

logic fq_push;
frontend_pkg::fetch_pkt_t fq_pkt;
logic credit_return;
logic fq_pop;
logic fq_valid;
frontend_pkg::fetch_pkt_t fq_head;

fetch_unit #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RESET_PC(RESET_PC)
) i_fetch_unit (
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .credit_return(credit_return),
    .fq_push(fq_push),
    .fq_pkt(fq_pkt)
);

fetch_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
) i_fetch_queue (
    .clk(clk),
    .reset(reset),
    .fq_push(fq_push),
    .fq_pkt(fq_pkt),
    .fq_pop(fq_pop),
    .fq_valid(fq_valid),
    .fq_head(fq_head),
    .credit_return(credit_return)
);

decode_stage i_decode_stage (
    .clk(clk),
    .reset(reset),
    .fq_valid(fq_valid),
    .fq_head(fq_head),
    .fq_pop(fq_pop),
    .dec_valid(dec_valid),
    .dec_ready(dec_ready),
    .dec_out(dec_out),
    .fe_ctrl(fe_ctrl)
);

endmodule

`default_nettype wire

//--- testbench/tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

localparam int unsigned QUEUE_DEPTH = 4;
localparam logic [31:0] RESET_PC = 32'h0000_0000;
localparam int CLK_PERIOD = 100;
localparam int N_ROWS = 3;
localparam int N_WORDS = 8;
localparam int HOLD_CYCLES = 16;
localparam int TIMEOUT_CYCLES = N_ROWS * N_WORDS * 20 + 200;
localparam logic [31:0] NOP_WORD = 32'h0000_0013;

typedef struct packed {
    logic [31:0] word;
    logic [8:0] itype;
    logic rd_we;
    logic [3:0] alu_op;
    logic a_sel;
    logic b_sel;
    logic [1:0] wb_sel;
    logic [2:0] ewb_sel;
    logic [31:0] imm;
    logic [2:0] has_reg;
    logic [1:0] pc_sel;
    logic pc_we;
} expect_t;

logic clk;
logic reset;
logic imem_req;
logic [31:0] imem_addr;
logic [31:0] imem_rdata = 32'h0;
logic dec_valid;
logic dec_ready;
frontend_pkg::decoded_t dec_out;
frontend_pkg::fe_ctrl_t fe_ctrl;

expect_t table_q [N_ROWS * N_WORDS];
int n_entries = 0;
logic [31:0] program_words [N_WORDS];
// dec_ready per row is held high, random, or held low and then random
int ready_mode [N_ROWS] = '{0, 1, 2};
int errors = 0;
int failed_tests = 0;

frontend_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RESET_PC(RESET_PC)
) i_dut (
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .dec_valid(dec_valid),
    .dec_ready(dec_ready),
    .dec_out(dec_out),
    .fe_ctrl(fe_ctrl)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// synchronous instruction memory, one cycle read latency
always @(posedge clk) begin
    if (imem_req) begin
        if (imem_addr[31:2] < N_WORDS) begin
            imem_rdata <= program_words[imem_addr[31:2]];
        end else begin
            imem_rdata <= NOP_WORD;
        end
    end
end

initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: decode output did not deliver all words in time");
    $display("Simulation failed");
    $finish;
end

task automatic add_entry(input logic [31:0] word, input logic [8:0] itype, input logic rd_we,
                         input logic [3:0] alu_op, input logic a_sel, input logic b_sel,
                         input logic [1:0] wb_sel, input logic [2:0] ewb_sel,
                         input logic [31:0] imm, input logic [2:0] has_reg,
                         input logic [1:0] pc_sel, input logic pc_we);
    table_q[n_entries] = '{word, itype, rd_we, alu_op, a_sel, b_sel, wb_sel, ewb_sel,
                           imm, has_reg, pc_sel, pc_we};
    n_entries++;
endtask

task automatic build_table();
    // word, itype, rd_we, alu_op, a_sel, b_sel, wb_sel, ewb_sel, imm, has_reg, pc_sel, pc_we
    add_entry(32'h00B50533, 9'h000, 1'b1, 4'h0, 1'b0, 1'b0, 2'd0, 3'd0, 32'h0, 3'b111, 2'd0, 1'b1);
    add_entry(32'h407302B3, 9'h000, 1'b1, 4'h8, 1'b0, 1'b0, 2'd0, 3'd0, 32'h0, 3'b111, 2'd0, 1'b1);
    add_entry(32'hFFF00093, 9'h000, 1'b1, 4'h0, 1'b0, 1'b1, 2'd0, 3'd0, 32'hFFFFFFFF, 3'b110,
              2'd0, 1'b1);
    add_entry(32'h4041D113, 9'h000, 1'b1, 4'hD, 1'b0, 1'b1, 2'd0, 3'd0, 32'h404, 3'b110, 2'd0, 1'b1);
    add_entry(32'hFF812203, 9'h100, 1'b1, 4'h0, 1'b0, 1'b0, 2'd1, 3'd0, 32'hFFFFFFF8, 3'b110,
              2'd0, 1'b1);
    add_entry(32'h00512623, 9'h080, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd0, 32'hC, 3'b011, 2'd0, 1'b1);
    add_entry(32'hFE2088E3, 9'h040, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd0, 32'hFFFFFFF0, 3'b011,
              2'd0, 1'b0);
    add_entry(32'h001000EF, 9'h020, 1'b1, 4'h0, 1'b0, 1'b0, 2'd0, 3'd1, 32'h800, 3'b100, 2'd1, 1'b1);
    // jalr to x0, lui, auipc, simd dot, simd widen, csrrw, unknown opcode, sb
    add_entry(32'h00408067, 9'h010, 1'b0, 4'h0, 1'b0, 1'b1, 2'd0, 3'd1, 32'h4, 3'b110, 2'd0, 1'b0);
    add_entry(32'h123451B7, 9'h000, 1'b1, 4'h0, 1'b0, 1'b1, 2'd0, 3'd2, 32'h12345000, 3'b100,
              2'd0, 1'b1);
    add_entry(32'hFFFFF217, 9'h000, 1'b1, 4'h0, 1'b1, 1'b1, 2'd0, 3'd0, 32'hFFFFF000, 3'b100,
              2'd0, 1'b1);
    add_entry(32'h0083830B, 9'h008, 1'b1, 4'h0, 1'b0, 1'b0, 2'd2, 3'd0, 32'h0, 3'b111, 2'd0, 1'b1);
    add_entry(32'h0005148B, 9'h004, 1'b1, 4'h0, 1'b0, 1'b0, 2'd0, 3'd4, 32'h0, 3'b111, 2'd0, 1'b1);
    add_entry(32'h300312F3, 9'h002, 1'b1, 4'h0, 1'b0, 1'b0, 2'd0, 3'd3, 32'h0, 3'b110, 2'd0, 1'b1);
    add_entry(32'h0000007F, 9'h001, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd0, 32'h0, 3'b000, 2'd0, 1'b0);
    add_entry(32'hFE000FA3, 9'h080, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd0, 32'hFFFFFFFF, 3'b011,
              2'd0, 1'b1);
    // nop, slli, xori, bltu, jal to x0, sra, csrrsi to x0, lh
    add_entry(32'h00000013, 9'h000, 1'b0, 4'h0, 1'b0, 1'b1, 2'd0, 3'd0, 32'h0, 3'b110, 2'd0, 1'b1);
    add_entry(32'h00341393, 9'h000, 1'b1, 4'h1, 1'b0, 1'b1, 2'd0, 3'd0, 32'h3, 3'b110, 2'd0, 1'b1);
    add_entry(32'h8004C493, 9'h000, 1'b1, 4'h4, 1'b0, 1'b1, 2'd0, 3'd0, 32'hFFFFF800, 3'b110,
              2'd0, 1'b1);
    add_entry(32'h7E41EF63, 9'h040, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd0, 32'h7FE, 3'b011, 2'd0, 1'b0);
    add_entry(32'hFFDFF06F, 9'h020, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd1, 32'hFFFFFFFC, 3'b100,
              2'd1, 1'b1);
    add_entry(32'h40D655B3, 9'h000, 1'b1, 4'hD, 1'b0, 1'b0, 2'd0, 3'd0, 32'h0, 3'b111, 2'd0, 1'b1);
    add_entry(32'h34026073, 9'h002, 1'b0, 4'h0, 1'b0, 1'b0, 2'd0, 3'd3, 32'h0, 3'b100, 2'd0, 1'b1);
    add_entry(32'h7FF79703, 9'h100, 1'b1, 4'h0, 1'b0, 1'b0, 2'd1, 3'd0, 32'h7FF, 3'b110, 2'd0, 1'b1);
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_word(input int row, input int idx);
    expect_t e;
    logic unsigned_branch;
    e = table_q[row * N_WORDS + idx];
    // bltu and bgeu compare unsigned
    unsigned_branch = e.itype[6] && (e.word[14:12] == 3'b110 || e.word[14:12] == 3'b111);
    check_value("dec_out.pc", dec_out.pc, RESET_PC + 32'(4 * idx));
    check_value("dec_out.itype", 32'(dec_out.itype), 32'(e.itype));
    check_value("dec_out.rd", 32'(dec_out.rd), 32'(e.word[11:7]));
    check_value("dec_out.rs1", 32'(dec_out.rs1), 32'(e.word[19:15]));
    check_value("dec_out.rs2", 32'(dec_out.rs2), 32'(e.word[24:20]));
    check_value("dec_out.rd_we", 32'(dec_out.rd_we), 32'(e.rd_we));
    check_value("dec_out.alu_op", 32'(dec_out.alu_op), 32'(e.alu_op));
    check_value("dec_out.a_sel", 32'(dec_out.a_sel), 32'(e.a_sel));
    check_value("dec_out.b_sel", 32'(dec_out.b_sel), 32'(e.b_sel));
    check_value("dec_out.wb_sel", 32'(dec_out.wb_sel), 32'(e.wb_sel));
    check_value("dec_out.ewb_sel", 32'(dec_out.ewb_sel), 32'(e.ewb_sel));
    check_value("dec_out.imm", dec_out.imm, e.imm);
    check_value("dec_out.has_reg", 32'(dec_out.has_reg), 32'(e.has_reg));
    check_value("dec_out.branch_u", 32'(dec_out.branch_u), 32'(unsigned_branch));
    check_value("dec_out.dmem_en", 32'(dec_out.dmem_en), 32'(e.itype[8] | e.itype[7]));
    check_value("fe_ctrl.pc_sel", 32'(fe_ctrl.pc_sel), 32'(e.pc_sel));
    check_value("fe_ctrl.pc_we", 32'(fe_ctrl.pc_we), 32'(e.pc_we));
endtask

task automatic apply_reset(input logic ready_init);
    reset <= 1'b1;
    dec_ready <= ready_init;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
endtask

task automatic run_row(input int row);
    int got;
    int cycles;
    int reqs;
    int issued;
    int errors_before;
    logic stalled;
    frontend_pkg::decoded_t held_out;
    frontend_pkg::fe_ctrl_t held_ctrl;
    got = 0;
    cycles = 0;
    reqs = 0;
    issued = 0;
    stalled = 1'b0;
    errors_before = errors;
    for (int i = 0; i < N_WORDS; i++) begin
        program_words[i] = table_q[row * N_WORDS + i].word;
    end
    apply_reset(ready_mode[row] == 0);
    while (got < N_WORDS) begin
        @(negedge clk);
        if (stalled) begin
            assert (dec_valid && dec_out === held_out && fe_ctrl === held_ctrl) else begin
                $display("Error at %0t: decode output changed while dec_ready was low", $time);
                errors++;
            end
        end
        // fetch reads sequential words from the reset pc
        if (imem_req) begin
            check_value("imem_addr", imem_addr, RESET_PC + 32'(4 * issued));
            issued++;
        end
        if (imem_req && cycles < HOLD_CYCLES) begin
            reqs++;
        end
        if (dec_valid && dec_ready) begin
            check_word(row, got);
            got++;
        end
        stalled = dec_valid && !dec_ready;
        held_out = dec_out;
        held_ctrl = fe_ctrl;
        cycles++;
        // fetch may run one request past a full queue, into the empty output register
        if (ready_mode[row] == 2 && cycles == HOLD_CYCLES) begin
            check_value("imem_req count", 32'(reqs), 32'(QUEUE_DEPTH + 1));
        end
        @(posedge clk);
        if (ready_mode[row] == 0) begin
            dec_ready <= 1'b1;
        end else if (ready_mode[row] == 2 && cycles < HOLD_CYCLES) begin
            dec_ready <= 1'b0;
        end else begin
            dec_ready <= ($urandom % 2) == 1;
        end
    end
    if (errors != errors_before) begin
        failed_tests++;
    end
    $display("test %0d, mode %0d: %0d words checked, %0d errors", row, ready_mode[row], got,
             errors - errors_before);
endtask

initial begin
    void'($urandom(6));
    reset = 1'b1;
    dec_ready = 1'b0;
    build_table();
    for (int row = 0; row < N_ROWS; row++) begin
        run_row(row);
    end
    $display("tests run %0d, tests with errors %0d, total errors %0d", N_ROWS, failed_tests,
             errors);
    if (failed_tests == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- sources.f
verilog/riscv_isa_pkg.sv
verilog/frontend_pkg.sv
verilog/fetch_unit.sv
verilog/fetch_queue.sv
verilog/inst_decoder.sv
verilog/decode_stage.sv
verilog/frontend_top.sv
testbench/tb_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build and run the front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frontend -f sources.f -o tb_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
